// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing
TOP = tb_breakout
FILELIST = project.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP) into $(LOG), check for pass"
	@echo "  clean  remove build products and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/ball_paddle_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module ball_paddle_motion (
	input wire i_clk,
	input wire i_rst,
	input wire breakout_pkg::step_cmd_t i_cmd,
	input wire [breakout_pkg::NUM_BRICKS-1:0] i_alive,
	output breakout_pkg::object_pos_t o_pos,
	output breakout_pkg::hit_event_t o_event
);

	logic dir_x;										// 1 right, 0 left
	logic dir_y;										// 1 down, 0 up
	logic dx_n;
	logic dy_n;
	breakout_pkg::coord_t pad_n;						// paddle after this frame's move
	breakout_pkg::coord_t bx_n;
	breakout_pkg::coord_t by_n;
	logic brick_hit;
	logic [breakout_pkg::IDX_W-1:0] brick_idx;
	breakout_pkg::object_pos_t pos_n;
	breakout_pkg::hit_event_t ev_n;

	// paddle move with clamp at both screen edges
	always_comb
	begin
		pad_n = o_pos.pad_x;
		case (i_cmd.pad)
			breakout_pkg::PAD_RIGHT:
				if (o_pos.pad_x >= breakout_pkg::PAD_X_MAX - breakout_pkg::PAD_STEP)
					pad_n = breakout_pkg::PAD_X_MAX;
				else
					pad_n = o_pos.pad_x + breakout_pkg::PAD_STEP;
			breakout_pkg::PAD_LEFT:
				if (o_pos.pad_x <= breakout_pkg::PAD_X_MIN + breakout_pkg::PAD_STEP)
					pad_n = breakout_pkg::PAD_X_MIN;
				else
					pad_n = o_pos.pad_x - breakout_pkg::PAD_STEP;
			default:
				pad_n = o_pos.pad_x;
		endcase
	end

	assign bx_n = dir_x ? o_pos.ball_x + breakout_pkg::BALL_STEP
		: o_pos.ball_x - breakout_pkg::BALL_STEP;
	assign by_n = dir_y ? o_pos.ball_y + breakout_pkg::BALL_STEP
		: o_pos.ball_y - breakout_pkg::BALL_STEP;

	// scan downwards so the lowest matching index is the one kept
	always_comb
	begin
		brick_hit = 1'b0;
		brick_idx = '0;
		for (int i = breakout_pkg::NUM_BRICKS - 1; i >= 0; i--)
		begin
			if (i_alive[i]
				&& bx_n >= breakout_pkg::BRICK_X_LO[i] && bx_n <= breakout_pkg::BRICK_X_HI[i]
				&& by_n >= breakout_pkg::BRICK_Y_LO[i] && by_n <= breakout_pkg::BRICK_Y_HI[i])
			begin
				brick_hit = 1'b1;
				brick_idx = breakout_pkg::IDX_W'(i);
			end
		end
	end

	always_comb
	begin
		pos_n = o_pos;
		pos_n.pad_x = pad_n;
		pos_n.ball_x = bx_n;
		pos_n.ball_y = by_n;
		dx_n = dir_x;
		dy_n = dir_y;
		ev_n = '0;
		if (brick_hit)
		begin
			dy_n = ~dir_y;								// top or bottom face, vertical only
			ev_n.hit = 1'b1;
			ev_n.idx = brick_idx;
		end
		if (bx_n <= breakout_pkg::WALL_LO)
			dx_n = 1'b1;								// left wall
		if (bx_n >= breakout_pkg::WALL_X_HI)
			dx_n = 1'b0;								// right wall
		if (by_n <= breakout_pkg::WALL_LO)
			dy_n = 1'b1;								// top wall
		if (by_n >= breakout_pkg::PAD_CONTACT_Y)
		begin
			if (bx_n >= pad_n - breakout_pkg::PAD_HALF_W
				&& bx_n <= pad_n + breakout_pkg::PAD_HALF_W)
				dy_n = 1'b0;							// paddle bounce
			else
			begin
				ev_n.miss = 1'b1;						// lost ball, serve again from centre
				pos_n = breakout_pkg::POS_START;
				dx_n = 1'b0;
				dy_n = 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_cmd.restart)
		begin
			o_pos <= breakout_pkg::POS_START;
			dir_x <= 1'b0;								// serve up-left
			dir_y <= 1'b0;
			o_event <= '0;
		end
		else if (i_cmd.step)
		begin
			o_pos <= pos_n;
			dir_x <= dx_n;
			dir_y <= dy_n;
			o_event <= ev_n;							// strobes line up with the new position
		end
		else
			o_event <= '0;								// hit and miss last one cycle
	end

endmodule

`default_nettype wire

// ==== design/breakout_pkg.sv ====
`default_nettype none

package breakout_pkg;

	localparam int COORD_W = 10;					// pixel coordinate width
	localparam int NUM_BRICKS = 10;
	localparam int IDX_W = 4;						// brick index width
	localparam int HIT_W = 2;						// remaining-hit counter width

	typedef logic [COORD_W-1:0] coord_t;

	localparam coord_t SCREEN_W = 640;
	localparam coord_t SCREEN_H = 480;
	localparam coord_t PAD_HALF_W = 32;				// paddle half width
	localparam coord_t PAD_HALF_H = 3;				// paddle half height
	localparam coord_t BALL_HALF = 2;				// ball half size, square ball
	localparam coord_t PAD_STEP = 3;				// paddle pixels per frame
	localparam coord_t BALL_STEP = 2;				// ball pixels per axis per frame
	localparam coord_t PAD_X0 = SCREEN_W / 2;		// paddle centre at start
	localparam coord_t PAD_Y0 = SCREEN_H - 10;		// 470, fixed row of the paddle
	localparam coord_t BALL_X0 = SCREEN_W / 2;
	localparam coord_t BALL_Y0 = 460;
	// ball bottom can reach the paddle top within one step from here
	localparam coord_t PAD_CONTACT_Y = PAD_Y0 - PAD_HALF_H - BALL_HALF - BALL_STEP;
	localparam coord_t PAD_X_MIN = PAD_HALF_W + 1;				// 33, left clamp
	localparam coord_t PAD_X_MAX = SCREEN_W - PAD_HALF_W - 1;	// 607, right clamp
	localparam coord_t WALL_LO = BALL_HALF + 1;				// left and top wall, 3
	localparam coord_t WALL_X_HI = SCREEN_W - BALL_HALF - 1;	// right wall, 637
	localparam logic [1:0] START_LIVES = 2'd3;

	// contact windows for the ball centre, brick rectangle grown by the ball
	localparam coord_t BRICK_X_LO [NUM_BRICKS] = '{138, 232, 346, 440, 184, 288, 392, 232, 346, 288};
	localparam coord_t BRICK_X_HI [NUM_BRICKS] = '{202, 296, 410, 504, 248, 352, 456, 296, 410, 352};
	localparam coord_t BRICK_Y_LO [NUM_BRICKS] = '{47, 47, 47, 47, 97, 97, 97, 147, 147, 197};
	localparam coord_t BRICK_Y_HI [NUM_BRICKS] = '{73, 73, 73, 73, 123, 123, 123, 173, 173, 203};
	localparam logic [HIT_W-1:0] BRICK_HITS [NUM_BRICKS] = '{3, 3, 3, 3, 2, 2, 2, 1, 1, 1};

	typedef enum logic [1:0] {ST_IDLE, ST_PLAY, ST_WIN, ST_LOSE} game_state_e;

	typedef enum logic [1:0] {PAD_HOLD, PAD_LEFT, PAD_RIGHT} pad_cmd_e;

	typedef struct packed {
		logic step;									// advance one frame
		logic restart;								// reload board, ball and paddle
		pad_cmd_e pad;
	} step_cmd_t;

	typedef struct packed {
		logic hit;									// brick idx was struck this frame
		logic [IDX_W-1:0] idx;
		logic miss;									// ball passed the paddle
	} hit_event_t;

	typedef struct packed {
		logic [NUM_BRICKS-1:0] alive;
		logic [1:0] lives;
		logic cleared;								// no brick left
		logic dead;									// no life left
	} play_status_t;

	typedef struct packed {
		coord_t ball_x;
		coord_t ball_y;
		coord_t pad_x;
		coord_t pad_y;								// display only, never moves
	} object_pos_t;

	localparam object_pos_t POS_START = '{ball_x: BALL_X0, ball_y: BALL_Y0,
		pad_x: PAD_X0, pad_y: PAD_Y0};

endpackage

`default_nettype wire

// ==== design/breakout_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module breakout_top (
	input wire i_clk,
	input wire i_rst,
	input wire i_frame_stb,						// one pulse per video frame
	input wire i_btn_left,
	input wire i_btn_right,
	input wire i_start,
	output breakout_pkg::object_pos_t o_pos,
	output logic [breakout_pkg::NUM_BRICKS-1:0] o_alive,
	output logic [1:0] o_lives,
	output breakout_pkg::game_state_e o_state
);

	breakout_pkg::step_cmd_t cmd;					// decode to execute and result
	breakout_pkg::hit_event_t hit_ev;				// execute to result
	breakout_pkg::play_status_t status;				// result back to decode

	game_sequencer game_sequencer_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_frame_stb(i_frame_stb),
		.i_btn_left(i_btn_left),
		.i_btn_right(i_btn_right),
		.i_start(i_start),
		.i_status(status),
		.o_cmd(cmd),
		.o_state(o_state)
	);

	ball_paddle_motion ball_paddle_motion_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_cmd(cmd),
		.i_alive(status.alive),						// only live bricks can be hit
		.o_pos(o_pos),
		.o_event(hit_ev)
	);

	brick_tally brick_tally_i (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_cmd(cmd),
		.i_event(hit_ev),
		.o_status(status)
	);

	assign o_alive = status.alive;
	assign o_lives = status.lives;

endmodule

`default_nettype wire

// ==== design/brick_tally.sv ====
`timescale 1ns/1ps
`default_nettype none

module brick_tally (
	input wire i_clk,
	input wire i_rst,
	input wire breakout_pkg::step_cmd_t i_cmd,
	input wire breakout_pkg::hit_event_t i_event,
	output breakout_pkg::play_status_t o_status
);

	logic [breakout_pkg::HIT_W-1:0] hits_left [breakout_pkg::NUM_BRICKS];	// per brick
	logic [1:0] lives;
	logic [breakout_pkg::NUM_BRICKS-1:0] alive;

	always_ff @(posedge i_clk)
	begin
		if (i_rst || i_cmd.restart)
		begin
			for (int i = 0; i < breakout_pkg::NUM_BRICKS; i++)
			begin
				hits_left[i] <= breakout_pkg::BRICK_HITS[i];	// 3, 2 or 1 by row
			end
			lives <= breakout_pkg::START_LIVES;
		end
		else
		begin
			if (i_event.hit && hits_left[i_event.idx] != '0)
				hits_left[i_event.idx] <= hits_left[i_event.idx] - 1'b1;
			if (i_event.miss && lives != 2'd0)
				lives <= lives - 2'd1;					// saturate at zero
		end
	end

	// a brick stays on screen while it still needs hits
	always_comb
	begin
		for (int i = 0; i < breakout_pkg::NUM_BRICKS; i++)
		begin
			alive[i] = (hits_left[i] != '0);
		end
	end

	always_comb
	begin
		o_status.alive = alive;
		o_status.lives = lives;
		o_status.cleared = (alive == '0);				// all bricks gone
		o_status.dead = (lives == 2'd0);
	end

endmodule

`default_nettype wire

// ==== design/game_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_sequencer (
	input wire i_clk,
	input wire i_rst,
	input wire i_frame_stb,
	input wire i_btn_left,						// active high
	input wire i_btn_right,						// active high
	input wire i_start,
	input wire breakout_pkg::play_status_t i_status,
	output breakout_pkg::step_cmd_t o_cmd,
	output breakout_pkg::game_state_e o_state
);

	breakout_pkg::game_state_e state_n;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_state <= breakout_pkg::ST_IDLE;
		else
			o_state <= state_n;
	end

	always_comb
	begin
		state_n = o_state;							// hold by default
		case (o_state)
			breakout_pkg::ST_IDLE:
				if (i_start)
					state_n = breakout_pkg::ST_PLAY;
			breakout_pkg::ST_PLAY:
				if (i_status.dead)					// losing beats a last-brick clear
					state_n = breakout_pkg::ST_LOSE;
				else if (i_status.cleared)
					state_n = breakout_pkg::ST_WIN;
			default:								// win or lose, wait for start
				if (i_start)
					state_n = breakout_pkg::ST_IDLE;
		endcase
	end

	always_comb
	begin
		o_cmd.step = i_frame_stb && (o_state == breakout_pkg::ST_PLAY);
		// any start press outside play reloads, so idle always shows a fresh board
		o_cmd.restart = i_start && (o_state != breakout_pkg::ST_PLAY);
		if (i_btn_right && !i_btn_left)
			o_cmd.pad = breakout_pkg::PAD_RIGHT;
		else if (i_btn_left && !i_btn_right)
			o_cmd.pad = breakout_pkg::PAD_LEFT;
		else
			o_cmd.pad = breakout_pkg::PAD_HOLD;		// both or neither
	end

endmodule

`default_nettype wire

// ==== project.f ====
design/breakout_pkg.sv
design/game_sequencer.sv
design/ball_paddle_motion.sv
design/brick_tally.sv
design/breakout_top.sv
verification/tb_clock_gen.sv
verification/tb_breakout.sv

// ==== verification/breakout_testdata.txt ====
# name start btn(0 none,1 left,2 right) frames | expected pad_x ball_x ball_y lives alive(hex) state
# state 0 idle, 1 play, 2 win, 3 lose; each line continues from the one before
reset_idle 0 0 3 320 320 460 3 3ff 0
serve_50 1 0 50 320 220 360 3 3ff 1
serve_100 0 0 50 320 120 260 3 3ff 1
pad_right 0 2 100 607 84 60 3 3ff 1
pad_left 0 1 200 33 484 28 3 3ff 1
miss_1 0 2 244 320 320 460 2 3ff 1
miss_2 0 2 644 320 320 460 1 3ff 1
miss_3 0 2 644 320 320 460 0 3f0 3
restart 1 0 2 320 320 460 3 3ff 0
top_wall 1 0 229 320 142 2 3 3ff 1
brick0_hit 0 0 23 320 188 48 3 3ff 1
row0_sweep 0 0 138 320 464 48 3 3ff 1
right_wall 0 0 87 320 638 130 3 3ff 1
paddle_bounce 0 0 167 320 304 464 3 3ff 1

// ==== verification/tb_breakout.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_breakout;

	localparam int MAX_TESTS = 32;
	localparam int FRAME_GAP = 10;					// cycles between frame strobes
	localparam int PAD_ROW = 470;					// paddle y stays on this row

	logic clk;
	logic rst;
	logic frame_stb;
	logic btn_left;
	logic btn_right;
	logic start;
	breakout_pkg::object_pos_t pos;
	logic [breakout_pkg::NUM_BRICKS-1:0] alive;
	logic [1:0] lives;
	breakout_pkg::game_state_e state;

	logic [127:0] t_name [MAX_TESTS];				// scenario columns from the data file
	int t_start [MAX_TESTS];
	int t_btn [MAX_TESTS];
	int t_frames [MAX_TESTS];
	int e_pad [MAX_TESTS];
	int e_bx [MAX_TESTS];
	int e_by [MAX_TESTS];
	int e_lives [MAX_TESTS];
	int e_alive [MAX_TESTS];
	int e_state [MAX_TESTS];
	int num_tests = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int test_errs = 0;
	int failed = 0;
	logic limit_set = 1'b0;

	tb_clock_gen clock_gen_i (
		.o_clk(clk),
		.o_rst(rst)
	);

	breakout_top breakout_top_i (
		.i_clk(clk),
		.i_rst(rst),
		.i_frame_stb(frame_stb),
		.i_btn_left(btn_left),
		.i_btn_right(btn_right),
		.i_start(start),
		.o_pos(pos),
		.o_alive(alive),
		.o_lives(lives),
		.o_state(state)
	);

	// limit is set once the scenarios are loaded
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit_set && cycles >= cycle_limit)
		begin
			$display("timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic load_tests();
		int fd;
		int cnt;
		int total;
		string line;
		fd = $fopen("verification/breakout_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
		end
		else
		begin
			total = 0;
			while (!$feof(fd) && num_tests < MAX_TESTS)
			begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() > 0 && line[0] != "#")	// skip column notes
				begin
					cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %h %d",
						t_name[num_tests], t_start[num_tests], t_btn[num_tests],
						t_frames[num_tests], e_pad[num_tests], e_bx[num_tests],
						e_by[num_tests], e_lives[num_tests], e_alive[num_tests],
						e_state[num_tests]);
					if (cnt == 10)
					begin
						total += t_frames[num_tests];
						num_tests++;
					end
				end
			end
			$fclose(fd);
			cycle_limit = total * FRAME_GAP + 100 * num_tests;
			limit_set = 1'b1;
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat (2) @(posedge clk);					// let the reload settle
	endtask

	task automatic send_frames(input int n);
		for (int f = 0; f < n; f++)
		begin
			if (f > 0)
				repeat (FRAME_GAP - 2) @(posedge clk);
			@(posedge clk);
			frame_stb <= 1'b1;
			@(posedge clk);
			frame_stb <= 1'b0;
		end
		repeat (4) @(posedge clk);					// state trails frames by 3 cycles
	endtask

	task automatic check_value(input string tname, input string field,
		input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("FAIL %0s %0s expected %0h actual %0h", tname, field, expected, actual);
		end
		if (expected != actual)
			test_errs++;
	endtask

	initial
	begin
		string tname;
		frame_stb <= 1'b0;
		btn_left <= 1'b0;
		btn_right <= 1'b0;
		start <= 1'b0;
		load_tests();
		@(posedge clk);
		while (rst)
			@(posedge clk);
		for (int i = 0; i < num_tests; i++)
		begin
			tname = $sformatf("%0s", t_name[i]);
			test_errs = 0;
			if (t_start[i] != 0)
				pulse_start();
			@(posedge clk);
			btn_left <= t_btn[i][0];				// code bit 0 left, bit 1 right
			btn_right <= t_btn[i][1];
			send_frames(t_frames[i]);
			@(negedge clk);							// sample away from the drive edge
			check_value(tname, "pad_x", e_pad[i], int'(pos.pad_x));
			check_value(tname, "pad_y", PAD_ROW, int'(pos.pad_y));
			check_value(tname, "ball_x", e_bx[i], int'(pos.ball_x));
			check_value(tname, "ball_y", e_by[i], int'(pos.ball_y));
			check_value(tname, "lives", e_lives[i], int'(lives));
			check_value(tname, "alive", e_alive[i], int'(alive));
			check_value(tname, "state", e_state[i], int'(state));
			if (test_errs == 0)
				$display("ok   %0s", tname);
			else
			begin
				$display("bad  %0s (%0d mismatches)", tname, test_errs);
				failed++;
			end
			@(posedge clk);
			btn_left <= 1'b0;
			btn_right <= 1'b0;
		end
		$display("tests run %0d, passed %0d, failed %0d", num_tests, num_tests - failed, failed);
		if (failed == 0 && num_tests > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	initial
	begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;					// 8 ns period
	end

	initial
	begin
		o_rst = 1'b1;
		repeat (3) @(posedge o_clk);				// hold reset for three edges
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire
